// ==== include/fsync_config.svh ====
// Node sizes for the 1-D node, where the aggregate width must be a power of two and at least 2

`ifndef FSYNC_CONFIG_SVH
`define FSYNC_CONFIG_SVH

// Message field widths
`define FSYNC_AGGR_W 4  // Aggregate mask bits, one level per bit
`define FSYNC_ID_W 4  // Barrier identifier
`define FSYNC_SRC_W 2  // Source seen on the child side

// Queues
`define FSYNC_FIFO_DEPTH 2  // Entries in each local and remote queue

// Port counts of the 1-D node
`define FSYNC_N_RX 2  // The two children
`define FSYNC_N_TX 1  // Link to the parent

`endif

// ==== hdl/fsync_msg_pkg.sv ====
// Message formats for the 1-D node, where the up-request source is always two bits wider

`include "fsync_config.svh"

package fsync_msg_pkg;

  // Request coming in from a child
  typedef struct packed {
    logic                    sync;  // One-cycle strobe
    logic [`FSYNC_AGGR_W-1:0] aggr;  // Aggregate mask
    logic [`FSYNC_ID_W-1:0]   id;
    logic [`FSYNC_SRC_W-1:0]  src;
  } fsync_req_t;

  // Wake response sent back to the source
  typedef struct packed {
    logic                   wake;
    logic [`FSYNC_SRC_W-1:0] dst;  // Same width as the request source
  } fsync_rsp_t;

  // Aggregated request forwarded to the parent
  typedef struct packed {
    logic                     sync;
    logic [`FSYNC_AGGR_W-1:0]  aggr;  // Mask shifted down one level
    logic [`FSYNC_ID_W-1:0]    id;
    logic [`FSYNC_SRC_W+1:0]   src;  // Source with direction bits appended
  } fsync_up_req_t;

  // Direction bits appended to the source, both set
  localparam logic [1:0] FSYNC_SD_BOTH = 2'b11;

endpackage

// ==== hdl/fsync_ctrl_pkg.sv ====
// Control types for the 1-D node, where level indices cover the aggregate mask width only

`include "fsync_config.svh"

package fsync_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    ROOT,
    AGGR
  } fsync_state_e;

  typedef logic [$clog2(`FSYNC_AGGR_W)-1:0] fsync_level_t;  // Highest set mask bit

  // Check request from a port FSM to the register file
  typedef struct packed {
    logic         check_local;
    logic         check_remote;
    fsync_level_t level;
  } fsync_rf_req_t;

  typedef struct packed {
    logic present;  // Partner arrival found
  } fsync_rf_rsp_t;

endpackage

// ==== hdl/fsync_port_fsm.sv ====
// Port control FSM that accepts one request every 2 cycles and drops requests while busy

`timescale 1ns/100ps

module fsync_port_fsm
  import fsync_msg_pkg::*;
  import fsync_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  fsync_req_t    req_i,
  input  logic          root_i,
  input  logic          local_i,
  input  fsync_rf_rsp_t rf_rsp_i,
  output fsync_rf_req_t rf_req_o,
  output logic          push_local_o,
  output fsync_rsp_t    local_rsp_o,
  output logic          push_remote_o,
  output fsync_up_req_t up_req_o
);

  fsync_state_e state_q, state_d;
  fsync_level_t level;
  fsync_req_t   req_q;  // Payload of the accepted request
  logic         accept;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Level encoder
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    level = '0;
    for (int unsigned i = 0; i < $bits(req_i.aggr); i++) begin
      if (req_i.aggr[i]) begin
        level = fsync_level_t'(i);  // Later bits win, so the highest is kept
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_d       = state_q;
    rf_req_o      = '0;
    rf_req_o.level = level;
    push_local_o  = 1'b0;
    push_remote_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (req_i.sync && root_i) begin
          state_d              = ROOT;
          rf_req_o.check_local = 1'b1;
        end else if (req_i.sync && local_i) begin
          state_d               = AGGR;
          rf_req_o.check_remote = 1'b1;
        end
      end
      ROOT: begin
        state_d      = IDLE;
        push_local_o = rf_rsp_i.present;  // Result of last cycle's check
      end
      AGGR: begin
        state_d       = IDLE;
        push_remote_o = rf_rsp_i.present;
      end
      default: state_d = IDLE;
    endcase
  end

  assign accept = rf_req_o.check_local | rf_req_o.check_remote;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  // Outgoing messages from the captured payload
  assign local_rsp_o.wake = 1'b1;
  assign local_rsp_o.dst  = req_q.src;  // Wake goes back to the source

  assign up_req_o.sync = req_q.sync;
  assign up_req_o.aggr = req_q.aggr >> 1;  // One level up the tree
  assign up_req_o.id   = req_q.id;
  assign up_req_o.src  = {req_q.src, FSYNC_SD_BOTH};

endmodule

// ==== hdl/fsync_barrier_rf.sv ====
// Arrival-pairing banks for exactly two receive ports, where port 0 wins a same-cycle pair

`timescale 1ns/100ps

`include "fsync_config.svh"

module fsync_barrier_rf
  import fsync_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  fsync_rf_req_t rf_req_i [`FSYNC_N_RX],
  output fsync_rf_rsp_t rf_rsp_o [`FSYNC_N_RX]
);

  localparam int unsigned n_levels = `FSYNC_AGGR_W;
  localparam int unsigned n_banks  = 2;  // Bank 0 local, bank 1 remote

  logic [`FSYNC_N_RX-1:0] hit [n_banks];  // Present per bank and port

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arrival banks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar b = 0; b < n_banks; b++) begin : gen_bank
    logic [n_levels-1:0]    arrive_q, arrive_d;
    logic [`FSYNC_N_RX-1:0] chk;
    logic [`FSYNC_N_RX-1:0] hit_b;
    logic                   pair;

    for (genvar p = 0; p < `FSYNC_N_RX; p++) begin : gen_chk
      assign chk[p] = (b == 0) ? rf_req_i[p].check_local : rf_req_i[p].check_remote;
    end

    // Both children arrive at once on the same level
    assign pair = chk[0] & chk[1] & (rf_req_i[0].level == rf_req_i[1].level);

    always_comb begin
      arrive_d = arrive_q;
      hit_b    = '0;
      if (pair) begin
        hit_b[0] = 1'b1;  // Bit left untouched
      end else begin
        for (int unsigned p = 0; p < `FSYNC_N_RX; p++) begin
          if (chk[p]) begin
            hit_b[p]                     = arrive_q[rf_req_i[p].level];
            arrive_d[rf_req_i[p].level] = ~arrive_q[rf_req_i[p].level];  // Set or clear
          end
        end
      end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
        arrive_q <= '0;
      end else begin
        arrive_q <= arrive_d;
      end
    end

    assign hit[b] = hit_b;
  end

  // Registered result, a port checks one bank at a time
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned p = 0; p < `FSYNC_N_RX; p++) begin
        rf_rsp_o[p] <= '0;
      end
    end else begin
      for (int unsigned p = 0; p < `FSYNC_N_RX; p++) begin
        rf_rsp_o[p].present <= hit[0][p] | hit[1][p];
      end
    end
  end

endmodule

// ==== hdl/fsync_fifo.sv ====
// FWFT queue with no back-pressure, where a push while full or a pop while empty is dropped

`timescale 1ns/100ps

module fsync_fifo #(
  parameter type         fifo_t = logic,
  parameter int unsigned depth  = 2
)(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  fifo_t data_i,
  input  logic  pop_i,
  output fifo_t data_o,
  output logic  empty_o,
  output logic  error_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  fifo_t            mem [depth];
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             full, do_push, do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    logic [ptr_w-1:0] nxt;
    if (ptr == ptr_w'(depth - 1)) begin
      nxt = '0;  // Wrap around
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full    = (count_q == cnt_w'(depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty_o;
  assign error_o = (push_i & full) | (pop_i & empty_o);  // Misuse flag
  assign data_o  = mem[rd_ptr_q];  // Head valid while not empty

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_q + cnt_w'(do_push) - cnt_w'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== hdl/fsync_cc.sv ====
// Core control of a 1-D node with no back-pressure, where errors are OR'd per port without latching

`timescale 1ns/100ps

`include "fsync_config.svh"

module fsync_cc
  import fsync_msg_pkg::*;
  import fsync_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  fsync_req_t    req_i [`FSYNC_N_RX],
  input  logic          root_i [`FSYNC_N_RX],
  input  logic          local_i [`FSYNC_N_RX],
  input  logic          overflow_rx_i [`FSYNC_N_RX],
  input  logic          overflow_tx_i [`FSYNC_N_TX],
  input  logic          local_pop_i [`FSYNC_N_RX],
  input  logic          remote_pop_i [`FSYNC_N_RX],
  output logic          local_empty_o [`FSYNC_N_RX],
  output fsync_rsp_t    local_rsp_o [`FSYNC_N_RX],
  output logic          remote_empty_o [`FSYNC_N_RX],
  output fsync_up_req_t remote_up_o [`FSYNC_N_RX],
  output logic          detected_error_o [`FSYNC_N_RX + `FSYNC_N_TX]
);

  fsync_rf_req_t rf_req [`FSYNC_N_RX];
  fsync_rf_rsp_t rf_rsp [`FSYNC_N_RX];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Receive ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < `FSYNC_N_RX; i++) begin : gen_rx
    logic          push_local, push_remote;
    logic          local_err, remote_err;
    fsync_rsp_t    local_rsp;
    fsync_up_req_t up_req;

    fsync_port_fsm i_port_fsm (
      .clk_i,
      .rst_ni,
      .req_i         ( req_i[i]    ),
      .root_i        ( root_i[i]   ),
      .local_i       ( local_i[i]  ),
      .rf_rsp_i      ( rf_rsp[i]   ),
      .rf_req_o      ( rf_req[i]   ),
      .push_local_o  ( push_local  ),
      .local_rsp_o   ( local_rsp   ),
      .push_remote_o ( push_remote ),
      .up_req_o      ( up_req      )
    );

    fsync_fifo #(
      .fifo_t ( fsync_rsp_t       ),
      .depth  ( `FSYNC_FIFO_DEPTH )
    ) i_local_fifo (
      .clk_i,
      .rst_ni,
      .push_i  ( push_local       ),
      .data_i  ( local_rsp        ),
      .pop_i   ( local_pop_i[i]   ),
      .data_o  ( local_rsp_o[i]   ),
      .empty_o ( local_empty_o[i] ),
      .error_o ( local_err        )
    );

    fsync_fifo #(
      .fifo_t ( fsync_up_req_t    ),
      .depth  ( `FSYNC_FIFO_DEPTH )
    ) i_remote_fifo (
      .clk_i,
      .rst_ni,
      .push_i  ( push_remote       ),
      .data_i  ( up_req            ),
      .pop_i   ( remote_pop_i[i]   ),
      .data_o  ( remote_up_o[i]    ),
      .empty_o ( remote_empty_o[i] ),
      .error_o ( remote_err        )
    );

    assign detected_error_o[i] = overflow_rx_i[i] | local_err | remote_err;
  end

  fsync_barrier_rf i_barrier_rf (
    .clk_i,
    .rst_ni,
    .rf_req_i ( rf_req ),
    .rf_rsp_o ( rf_rsp )
  );

  // Transmit side only reports link overflow
  for (genvar i = 0; i < `FSYNC_N_TX; i++) begin : gen_tx
    assign detected_error_o[`FSYNC_N_RX + i] = overflow_tx_i[i];
  end

endmodule

// ==== test/fsync_cc_properties.sv ====
// Assertions bound into fsync_cc, written for exactly two receive ports

`timescale 1ns/100ps

`include "fsync_config.svh"

module fsync_cc_properties (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   local_empty_i [`FSYNC_N_RX],
  input logic                   remote_empty_i [`FSYNC_N_RX],
  input logic [`FSYNC_N_RX-1:0] push_i,  // Local or remote push per port
  input logic [`FSYNC_N_RX-1:0] idle_i   // Port FSM in IDLE
);

  int fail_count = 0;

  for (genvar p = 0; p < `FSYNC_N_RX; p++) begin : gen_port
    // Queues stay empty while reset is held
    assert property (@(posedge clk_i) !rst_ni |-> local_empty_i[p] && remote_empty_i[p])
      else begin
        $error("Queue of port %0d not empty during reset", p);
        fail_count++;
      end

    // First edge out of reset still sees empty queues
    assert property (@(posedge clk_i) $rose(rst_ni) |-> local_empty_i[p] && remote_empty_i[p])
      else begin
        $error("Queue of port %0d not empty after reset", p);
        fail_count++;
      end

    assert property (@(posedge clk_i) disable iff (!rst_ni) push_i[p] |-> !idle_i[p])
      else begin
        $error("Port %0d pushed while its FSM was idle", p);
        fail_count++;
      end
  end

endmodule

bind fsync_cc fsync_cc_properties i_props (
  .clk_i,
  .rst_ni,
  .local_empty_i  ( local_empty_o  ),
  .remote_empty_i ( remote_empty_o ),
  .push_i         ( {gen_rx[1].push_local | gen_rx[1].push_remote,
                     gen_rx[0].push_local | gen_rx[0].push_remote} ),
  .idle_i         ( {gen_rx[1].i_port_fsm.state_q == fsync_ctrl_pkg::IDLE,
                     gen_rx[0].i_port_fsm.state_q == fsync_ctrl_pkg::IDLE} )
);

// ==== test/fsync_cc_checker.sv ====
// Cycle model of the 2-child node, which expects inputs to change only just after the rising edge

`timescale 1ns/100ps

`include "fsync_config.svh"

module fsync_cc_checker
  import fsync_msg_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  fsync_req_t    req_i [`FSYNC_N_RX],
  input  logic          root_i [`FSYNC_N_RX],
  input  logic          local_i [`FSYNC_N_RX],
  input  logic          overflow_rx_i [`FSYNC_N_RX],
  input  logic          overflow_tx_i [`FSYNC_N_TX],
  input  logic          local_pop_i [`FSYNC_N_RX],
  input  logic          remote_pop_i [`FSYNC_N_RX],
  input  logic          local_empty_i [`FSYNC_N_RX],
  input  fsync_rsp_t    local_rsp_i [`FSYNC_N_RX],
  input  logic          remote_empty_i [`FSYNC_N_RX],
  input  fsync_up_req_t remote_up_i [`FSYNC_N_RX],
  input  logic          detected_error_i [`FSYNC_N_RX + `FSYNC_N_TX],
  output int            checks_o,
  output int            errors_o
);

  localparam int unsigned depth = `FSYNC_FIFO_DEPTH;

  fsync_rsp_t               local_q [`FSYNC_N_RX][$];  // Expected queue contents
  fsync_up_req_t            remote_q [`FSYNC_N_RX][$];
  logic [`FSYNC_AGGR_W-1:0] arrived [2];  // Waiting arrival, bank 0 local and bank 1 remote
  logic                     busy [`FSYNC_N_RX];
  logic                     push_local [`FSYNC_N_RX];  // Push expected in the current cycle
  logic                     push_remote [`FSYNC_N_RX];
  fsync_req_t               held [`FSYNC_N_RX];
  int                       checks = 0;
  int                       errors = 0;

  assign checks_o = checks;
  assign errors_o = errors;

  function automatic int level_of(input logic [`FSYNC_AGGR_W-1:0] aggr);
    int lvl;
    lvl = 0;
    for (int i = 0; i < `FSYNC_AGGR_W; i++) begin
      if (aggr[i]) begin
        lvl = i;
      end
    end
    return lvl;
  endfunction

  task automatic expect_eq(input string what, input int port, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at time %0t: %s of port %0d is 0x%0h, expected 0x%0h",
               $time, what, port, got, exp);
    end
  endtask

  task automatic reset_model();
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      local_q[p].delete();
      remote_q[p].delete();
      busy[p]        = 1'b0;
      push_local[p]  = 1'b0;
      push_remote[p] = 1'b0;
    end
    arrived[0] = '0;
    arrived[1] = '0;
  endtask

  task automatic compare_outputs();
    logic err;
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      err = overflow_rx_i[p]
          | (push_local[p] & (local_q[p].size() == depth))
          | (push_remote[p] & (remote_q[p].size() == depth))
          | (local_pop_i[p] & (local_q[p].size() == 0))
          | (remote_pop_i[p] & (remote_q[p].size() == 0));
      expect_eq("error flag", p, detected_error_i[p], err);
      expect_eq("local empty", p, local_empty_i[p], local_q[p].size() == 0);
      expect_eq("remote empty", p, remote_empty_i[p], remote_q[p].size() == 0);
      if (local_q[p].size() > 0) begin
        expect_eq("wake response", p, local_rsp_i[p], local_q[p][0]);
      end
      if (remote_q[p].size() > 0) begin
        expect_eq("up-request", p, remote_up_i[p], remote_q[p][0]);
      end
    end
    for (int t = 0; t < `FSYNC_N_TX; t++) begin
      expect_eq("tx error flag", t, detected_error_i[`FSYNC_N_RX + t], overflow_tx_i[t]);
    end
  endtask

  // Queue changes at the coming edge, a full queue drops the push even with a pop
  task automatic update_queues();
    logic local_full;
    logic remote_full;
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      local_full  = local_q[p].size() == depth;
      remote_full = remote_q[p].size() == depth;
      if (local_pop_i[p] && local_q[p].size() > 0) begin
        void'(local_q[p].pop_front());
      end
      if (remote_pop_i[p] && remote_q[p].size() > 0) begin
        void'(remote_q[p].pop_front());
      end
      if (push_local[p] && !local_full) begin
        local_q[p].push_back(fsync_rsp_t'{wake: 1'b1, dst: held[p].src});
      end
      if (push_remote[p] && !remote_full) begin
        remote_q[p].push_back(fsync_up_req_t'{sync: 1'b1, aggr: held[p].aggr >> 1,
                                              id: held[p].id, src: {held[p].src, 2'b11}});
      end
    end
  endtask

  task automatic accept_requests();
    logic acc [`FSYNC_N_RX];
    int   bank [`FSYNC_N_RX];
    int   lvl [`FSYNC_N_RX];
    logic hit [`FSYNC_N_RX];
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      acc[p]  = !busy[p] && req_i[p].sync && (root_i[p] || local_i[p]);
      bank[p] = root_i[p] ? 0 : 1;
      lvl[p]  = level_of(req_i[p].aggr);
      hit[p]  = 1'b0;
      if (acc[p]) begin
        held[p] = req_i[p];
      end
    end
    if (acc[0] && acc[1] && bank[0] == bank[1] && lvl[0] == lvl[1]) begin
      hit[0] = 1'b1;  // Pair within one cycle, arrival bit kept
    end else begin
      for (int p = 0; p < `FSYNC_N_RX; p++) begin
        if (acc[p]) begin
          hit[p]                  = arrived[bank[p]][lvl[p]];
          arrived[bank[p]][lvl[p]] = ~hit[p];
        end
      end
    end
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      push_local[p]  = acc[p] && hit[p] && bank[p] == 0;
      push_remote[p] = acc[p] && hit[p] && bank[p] == 1;
      busy[p]        = acc[p];  // Port ignores requests for one cycle
    end
  endtask

  // Mid-cycle sampling, inputs and outputs are settled here
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      reset_model();
    end else begin
      compare_outputs();
      update_queues();
      accept_requests();
    end
  end

endmodule

// ==== test/tb_fsync_cc.sv ====
// Testbench for the 2-child node, with stimulus tuned to the default sizes of the config header

`timescale 1ns/100ps

`include "fsync_config.svh"

module tb_fsync_cc
  import fsync_msg_pkg::*;
();

  localparam int unsigned clk_period     = 10;
  localparam int unsigned n_table        = 22;
  localparam int unsigned n_rand         = 40;
  localparam int unsigned timeout_cycles = (n_table + n_rand) * 4 + 40;

  typedef struct packed {
    logic [1:0]               ports;  // Bit per receive port
    logic                     sync;
    logic                     root;
    logic                     loc;
    logic                     hold;  // Repeat the request in the busy cycle
    logic [`FSYNC_AGGR_W-1:0] aggr;
    logic [`FSYNC_ID_W-1:0]   id;
    logic [`FSYNC_SRC_W-1:0]  src;
    logic [1:0]               lpop;
    logic [1:0]               rpop;
    logic [2:0]               ovf;  // Bit 0 rx0, bit 1 rx1, bit 2 tx
  } stim_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus table with one entry per 2 cycles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  stim_t stim_table [n_table] = '{
    '{2'b01, 1'b1, 1'b1, 1'b0, 1'b0, 4'b0100, 4'h1, 2'd1, 2'b00, 2'b00, 3'b000},  // Root pair
    '{2'b10, 1'b1, 1'b1, 1'b0, 1'b0, 4'b0110, 4'h1, 2'd2, 2'b00, 2'b00, 3'b000},
    '{2'b01, 1'b1, 1'b0, 1'b1, 1'b0, 4'b1000, 4'h5, 2'd3, 2'b00, 2'b00, 3'b000},  // Aggr pair
    '{2'b10, 1'b1, 1'b0, 1'b1, 1'b0, 4'b1001, 4'h5, 2'd0, 2'b00, 2'b00, 3'b000},
    '{2'b11, 1'b1, 1'b1, 1'b0, 1'b0, 4'b0010, 4'h2, 2'd1, 2'b00, 2'b00, 3'b000},  // Same cycle
    '{2'b10, 1'b1, 1'b1, 1'b0, 1'b0, 4'b0011, 4'h2, 2'd2, 2'b00, 2'b00, 3'b000},
    '{2'b01, 1'b1, 1'b1, 1'b0, 1'b0, 4'b0010, 4'h2, 2'd3, 2'b10, 2'b10, 3'b000},
    '{2'b01, 1'b1, 1'b0, 1'b0, 1'b0, 4'b0001, 4'h3, 2'd0, 2'b00, 2'b00, 3'b000},  // No role
    '{2'b10, 1'b0, 1'b1, 1'b0, 1'b0, 4'b0001, 4'h3, 2'd0, 2'b00, 2'b00, 3'b000},  // No sync
    '{2'b01, 1'b1, 1'b1, 1'b0, 1'b1, 4'b0001, 4'h3, 2'd1, 2'b00, 2'b00, 3'b000},  // While busy
    '{2'b10, 1'b1, 1'b1, 1'b0, 1'b0, 4'b0001, 4'h3, 2'd2, 2'b01, 2'b00, 3'b000},
    '{2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000, 4'h0, 2'd0, 2'b01, 2'b00, 3'b000},
    '{2'b11, 1'b1, 1'b0, 1'b1, 1'b0, 4'b0100, 4'h6, 2'd1, 2'b00, 2'b00, 3'b000},  // Fill queue
    '{2'b11, 1'b1, 1'b0, 1'b1, 1'b0, 4'b0101, 4'h7, 2'd2, 2'b00, 2'b00, 3'b000},
    '{2'b11, 1'b1, 1'b0, 1'b1, 1'b0, 4'b0110, 4'h8, 2'd3, 2'b00, 2'b00, 3'b000},
    '{2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000, 4'h0, 2'd0, 2'b10, 2'b01, 3'b000},  // Drain
    '{2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000, 4'h0, 2'd0, 2'b00, 2'b01, 3'b000},
    '{2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000, 4'h0, 2'd0, 2'b00, 2'b01, 3'b000},
    '{2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000, 4'h0, 2'd0, 2'b10, 2'b00, 3'b000},
    '{2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000, 4'h0, 2'd0, 2'b00, 2'b00, 3'b001},  // Overflow
    '{2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000, 4'h0, 2'd0, 2'b00, 2'b00, 3'b010},
    '{2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000, 4'h0, 2'd0, 2'b00, 2'b00, 3'b100}
  };

  logic          clk;
  logic          rst_n;
  fsync_req_t    req [`FSYNC_N_RX];
  logic          root [`FSYNC_N_RX];
  logic          loc [`FSYNC_N_RX];
  logic          ovf_rx [`FSYNC_N_RX];
  logic          ovf_tx [`FSYNC_N_TX];
  logic          lpop [`FSYNC_N_RX];
  logic          rpop [`FSYNC_N_RX];
  logic          lempty [`FSYNC_N_RX];
  fsync_rsp_t    lrsp [`FSYNC_N_RX];
  logic          rempty [`FSYNC_N_RX];
  fsync_up_req_t rup [`FSYNC_N_RX];
  logic          derr [`FSYNC_N_RX + `FSYNC_N_TX];
  int            checks;
  int            value_errors;
  logic [31:0]   lfsr_q = 32'h4ec46f75;

  fsync_cc i_dut (
    .clk_i            ( clk    ),
    .rst_ni           ( rst_n  ),
    .req_i            ( req    ),
    .root_i           ( root   ),
    .local_i          ( loc    ),
    .overflow_rx_i    ( ovf_rx ),
    .overflow_tx_i    ( ovf_tx ),
    .local_pop_i      ( lpop   ),
    .remote_pop_i     ( rpop   ),
    .local_empty_o    ( lempty ),
    .local_rsp_o      ( lrsp   ),
    .remote_empty_o   ( rempty ),
    .remote_up_o      ( rup    ),
    .detected_error_o ( derr   )
  );

  fsync_cc_checker i_checker (
    .clk_i            ( clk          ),
    .rst_ni           ( rst_n        ),
    .req_i            ( req          ),
    .root_i           ( root         ),
    .local_i          ( loc          ),
    .overflow_rx_i    ( ovf_rx       ),
    .overflow_tx_i    ( ovf_tx       ),
    .local_pop_i      ( lpop         ),
    .remote_pop_i     ( rpop         ),
    .local_empty_i    ( lempty       ),
    .local_rsp_i      ( lrsp         ),
    .remote_empty_i   ( rempty       ),
    .remote_up_i      ( rup          ),
    .detected_error_i ( derr         ),
    .checks_o         ( checks       ),
    .errors_o         ( value_errors )
  );

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic logic [31:0] draw_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic stim_t random_entry();
    stim_t       e;
    logic [31:0] v;
    v       = draw_bits(2);
    e.ports = v[1:0];
    e.sync  = lfsr_step();
    e.root  = lfsr_step();
    e.loc   = lfsr_step();
    e.hold  = lfsr_step();
    v       = draw_bits(`FSYNC_AGGR_W);
    e.aggr  = v[`FSYNC_AGGR_W-1:0];
    if (e.aggr == '0) begin
      e.aggr[0] = 1'b1;  // Keep the mask meaningful
    end
    v      = draw_bits(`FSYNC_ID_W);
    e.id   = v[`FSYNC_ID_W-1:0];
    v      = draw_bits(`FSYNC_SRC_W);
    e.src  = v[`FSYNC_SRC_W-1:0];
    v      = draw_bits(2);
    e.lpop = v[1:0];
    v      = draw_bits(2);
    e.rpop = v[1:0];
    v      = draw_bits(3) & draw_bits(3);  // Rarer than pops
    e.ovf  = v[2:0];
    return e;
  endfunction

  task automatic drive_inputs(input stim_t e, input logic req_on, input logic side_on);
    for (int p = 0; p < `FSYNC_N_RX; p++) begin
      req[p].sync = e.sync & e.ports[p] & req_on;
      req[p].aggr = e.aggr;
      req[p].id   = e.id;
      req[p].src  = e.src;
      root[p]     = e.root & e.ports[p] & req_on;
      loc[p]      = e.loc & e.ports[p] & req_on;
      lpop[p]     = e.lpop[p] & side_on;
      rpop[p]     = e.rpop[p] & side_on;
      ovf_rx[p]   = e.ovf[p] & side_on;
    end
    ovf_tx[0] = e.ovf[2] & side_on;
  endtask

  task automatic apply_entry(input stim_t e);
    @(posedge clk);
    #1;
    drive_inputs(e, 1'b1, 1'b1);
    @(posedge clk);
    #1;
    drive_inputs(e, e.hold, 1'b0);  // Port is busy in the second cycle
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(timeout_cycles * clk_period);
    $display("Run did not finish within %0d cycles, the stimulus hung", timeout_cycles);
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    int total;
    rst_n = 1'b0;
    drive_inputs('0, 1'b0, 1'b0);
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < n_table; i++) begin
      apply_entry(stim_table[i]);
    end
    for (int i = 0; i < n_rand; i++) begin
      apply_entry(random_entry());
    end
    @(posedge clk);
    #1;
    drive_inputs('0, 1'b0, 1'b0);
    repeat (4) @(posedge clk);  // Let the last pushes land
    total = value_errors + i_dut.i_props.fail_count;
    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             checks, value_errors, i_dut.i_props.fail_count);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
hdl/fsync_msg_pkg.sv
hdl/fsync_ctrl_pkg.sv
hdl/fsync_port_fsm.sv
hdl/fsync_barrier_rf.sv
hdl/fsync_fifo.sv
hdl/fsync_cc.sv
test/fsync_cc_properties.sv
test/fsync_cc_checker.sv
test/tb_fsync_cc.sv

// ==== Bender.yml ====
package:
  name: fsync_cc

export_include_dirs:
  - include

sources:
  - files:
      - hdl/fsync_msg_pkg.sv
      - hdl/fsync_ctrl_pkg.sv
      - hdl/fsync_port_fsm.sv
      - hdl/fsync_barrier_rf.sv
      - hdl/fsync_fifo.sv
      - hdl/fsync_cc.sv
  - target: test
    files:
      - test/fsync_cc_properties.sv
      - test/fsync_cc_checker.sv
      - test/tb_fsync_cc.sv
